// ==== cache_pkg.sv ====
// Shared definitions for the two-way blocking write-back cache
// Address split, message structs, request types and controller states
package cache_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int WORD_BITS      = 32;
  localparam int LINE_BITS      = 128;
  localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 8;

  // Address field boundaries
  localparam int OFF_LSB = 2;
  localparam int IDX_LSB = 4;
  localparam int TAG_LSB = 7;

  typedef logic [31:0]              addr_t;
  typedef logic [WORD_BITS-1:0]     word_t;
  typedef logic [LINE_BITS-1:0]     line_t;
  typedef logic [31-TAG_LSB:0]      tag_t;
  typedef logic [TAG_LSB-IDX_LSB-1:0] idx_t;
  typedef logic [IDX_LSB-OFF_LSB-1:0] word_off_t;
  typedef logic [LINE_BITS/8-1:0]   wben_t;
  typedef logic [0:0]               req_type_t;

  localparam req_type_t TYPE_READ  = 1'b0;
  localparam req_type_t TYPE_WRITE = 1'b1;

  // --------------------------------------------------
  // Messages
  // --------------------------------------------------
  typedef struct packed {
    req_type_t op;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  typedef struct packed {
    req_type_t op;
    word_t     data;
  } cache_resp_t;

  // Read is a refill, write is an eviction
  typedef struct packed {
    req_type_t op;
    addr_t     addr;
    line_t     data;
  } mem_req_t;

  typedef struct packed {
    req_type_t op;
    line_t     data;
  } mem_resp_t;

  typedef enum logic [3:0] {
    IDLE, TAG_CHECK, READ_ACCESS, WRITE_ACCESS,
    REFILL_REQUEST, REFILL_WAIT, REFILL_UPDATE,
    EVICT_PREPARE, EVICT_REQUEST, EVICT_WAIT, WAIT_RESP
  } ctrl_state_t;

endpackage

// ==== cache_ctrl_fsm.sv ====
// Cache controller FSM
// Sequences tag check, data access, eviction and refill for one request
`timescale 1ns/1ps

module cache_ctrl_fsm
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Handshakes
  input  logic      cachereq_val,
  output logic      cachereq_rdy,
  output logic      cacheresp_val,
  input  logic      cacheresp_rdy,
  output logic      memreq_val,
  input  logic      memreq_rdy,
  input  logic      memresp_val,
  output logic      memresp_rdy,

  // Status from the data modules
  input  req_type_t req_type,
  input  logic      hit,
  input  logic      victim_dirty,

  // Enables and selects
  output logic      req_en,
  output logic      refill_en,
  output logic      tag_ren,
  output logic      tag_wen,
  output logic      data_wen,
  output logic      refill_sel,
  output logic      read_en,
  output logic      evict_sel,
  output logic      way_record_en,
  output logic      valid_wen,
  output logic      dirty_wen,
  output logic      dirty_in,
  output logic      lru_wen
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        is_write;

  assign is_write = (req_type == TYPE_WRITE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE:           if (cachereq_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (hit)               state_next = is_write ? WRITE_ACCESS : READ_ACCESS;
        else if (victim_dirty) state_next = EVICT_PREPARE;
        else                   state_next = REFILL_REQUEST;
      end
      READ_ACCESS:    state_next = WAIT_RESP;
      WRITE_ACCESS:   state_next = WAIT_RESP;
      REFILL_REQUEST: if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:    if (memresp_val) state_next = REFILL_UPDATE;
      // Finish the access that missed
      REFILL_UPDATE:  state_next = is_write ? WRITE_ACCESS : READ_ACCESS;
      EVICT_PREPARE:  state_next = EVICT_REQUEST;
      EVICT_REQUEST:  if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:     if (memresp_val) state_next = REFILL_REQUEST;
      WAIT_RESP:      if (cacheresp_rdy) state_next = IDLE;
      default:        state_next = IDLE;
    endcase
  end

  // --------------------------------------------------
  // Control outputs
  // --------------------------------------------------
  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    req_en        = 1'b0;
    refill_en     = 1'b0;
    tag_ren       = 1'b0;
    tag_wen       = 1'b0;
    data_wen      = 1'b0;
    refill_sel    = 1'b0;
    read_en       = 1'b0;
    evict_sel     = 1'b0;
    way_record_en = 1'b0;
    valid_wen     = 1'b0;
    dirty_wen     = 1'b0;
    dirty_in      = 1'b0;
    lru_wen       = 1'b0;
    case (state)
      IDLE: begin
        cachereq_rdy = 1'b1;
        req_en       = cachereq_val;
      end
      TAG_CHECK: begin
        tag_ren       = 1'b1;
        way_record_en = 1'b1;
      end
      READ_ACCESS: begin
        read_en = 1'b1;
        lru_wen = 1'b1;
      end
      WRITE_ACCESS: begin
        tag_wen   = 1'b1;
        data_wen  = 1'b1;
        valid_wen = 1'b1;
        dirty_wen = 1'b1;
        dirty_in  = 1'b1;
        lru_wen   = 1'b1;
      end
      REFILL_REQUEST: memreq_val = 1'b1;
      REFILL_WAIT: begin
        memresp_rdy = 1'b1;
        refill_en   = memresp_val;
      end
      // Fresh line is clean until the write access marks it
      REFILL_UPDATE: begin
        tag_wen    = 1'b1;
        data_wen   = 1'b1;
        refill_sel = 1'b1;
        valid_wen  = 1'b1;
        dirty_wen  = 1'b1;
      end
      EVICT_PREPARE: begin
        tag_ren = 1'b1;
        read_en = 1'b1;
      end
      EVICT_REQUEST: begin
        memreq_val = 1'b1;
        evict_sel  = 1'b1;
      end
      EVICT_WAIT: memresp_rdy = 1'b1;
      WAIT_RESP:  cacheresp_val = 1'b1;
      default: ;
    endcase
  end

  // Producers hold val until the transfer
  assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val)
    else $error("memreq_val dropped without memreq_rdy");

  assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val)
    else $error("cacheresp_val dropped without cacheresp_rdy");

endmodule

// ==== cache_tag_state.sv ====
// Tag and state arrays for the two cache ways
// Valid, dirty and LRU bits, hit detection and the recorded way
`timescale 1ns/1ps

module cache_tag_state
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  addr_t req_addr,
  input  logic  tag_ren,
  input  logic  tag_wen,
  input  logic  way_record_en,
  input  logic  valid_wen,
  input  logic  dirty_wen,
  input  logic  dirty_in,
  input  logic  lru_wen,
  output logic  hit,
  output logic  victim_dirty,
  output logic  way,
  output tag_t  victim_tag
);

  tag_t                tag_array  [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_bits [NUM_WAYS];
  logic [NUM_SETS-1:0] lru_bits;

  idx_t                idx;
  tag_t                req_tag;
  logic [NUM_WAYS-1:0] way_hit;
  logic                sel_way;

  assign idx     = req_addr[IDX_LSB +: $bits(idx_t)];
  assign req_tag = req_addr[TAG_LSB +: $bits(tag_t)];

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_bits[w][idx] && (tag_array[w][idx] == req_tag);
    end
  end

  // Hit way, else the least recently used one
  assign sel_way = way_hit[1] ? 1'b1 : (way_hit[0] ? 1'b0 : lru_bits[idx]);

  assign hit          = tag_ren && (|way_hit);
  assign victim_dirty = tag_ren && valid_bits[sel_way][idx] && dirty_bits[sel_way][idx];
  assign victim_tag   = tag_array[way][idx];

  // --------------------------------------------------
  // Array and way updates
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_bits[w] <= '0;
        dirty_bits[w] <= '0;
        for (int s = 0; s < NUM_SETS; s++) begin
          tag_array[w][s] <= '0;
        end
      end
      lru_bits <= '0;
      way      <= 1'b0;
    end else begin
      if (way_record_en) way <= sel_way;
      if (tag_wen)   tag_array[way][idx]  <= req_tag;
      if (valid_wen) valid_bits[way][idx] <= 1'b1;
      if (dirty_wen) dirty_bits[way][idx] <= dirty_in;
      // Other way becomes the replacement candidate
      if (lru_wen)   lru_bits[idx] <= ~way;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(way_hit[0] && way_hit[1]))
    else $error("address hits in both ways");

endmodule

// ==== cache_data_path.sv ====
// Cache data path with request register and two-way data array
// Word reads and writes, refill merge and memory request assembly
`timescale 1ns/1ps

module cache_data_path
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  cache_req_t  cachereq,
  input  logic        req_en,
  input  logic        refill_en,
  input  logic        data_wen,
  input  logic        refill_sel,
  input  logic        read_en,
  input  logic        evict_sel,
  input  logic        way,
  input  tag_t        victim_tag,
  input  mem_resp_t   memresp,
  output req_type_t   req_type,
  output addr_t       req_addr,
  output cache_resp_t cacheresp,
  output mem_req_t    memreq
);

  cache_req_t req_reg;
  line_t      data_array [NUM_WAYS][NUM_SETS];
  line_t      refill_line;
  line_t      read_line;
  line_t      fill_line;
  line_t      write_line;
  wben_t      wben;
  idx_t       idx;
  word_off_t  off;

  assign req_type = req_reg.op;
  assign req_addr = req_reg.addr;
  assign idx      = req_reg.addr[IDX_LSB +: $bits(idx_t)];
  assign off      = req_reg.addr[OFF_LSB +: $bits(word_off_t)];

  always_ff @(posedge clk) begin
    if (reset) begin
      req_reg <= '0;
    end else if (req_en) begin
      req_reg <= cachereq;
    end
  end

  always_ff @(posedge clk) begin
    if (refill_en) refill_line <= memresp.data;
    // Word source for reads, line source for evictions
    if (read_en)   read_line   <= data_array[way][idx];
  end

  // Store data folded into the fresh line
  always_comb begin
    fill_line = refill_line;
    if (req_reg.op == TYPE_WRITE) fill_line[off*WORD_BITS +: WORD_BITS] = req_reg.data;
  end

  assign write_line = refill_sel ? fill_line : {WORDS_PER_LINE{req_reg.data}};
  assign wben       = refill_sel ? '1
                    : wben_t'({(WORD_BITS/8){1'b1}}) << (off * (WORD_BITS/8));

  always_ff @(posedge clk) begin
    if (data_wen) begin
      for (int b = 0; b < LINE_BITS/8; b++) begin
        if (wben[b]) data_array[way][idx][b*8 +: 8] <= write_line[b*8 +: 8];
      end
    end
  end

  assign cacheresp.op   = req_reg.op;
  assign cacheresp.data = read_line[off*WORD_BITS +: WORD_BITS];

  // --------------------------------------------------
  // Memory request for a refill read or a victim write
  // --------------------------------------------------
  always_comb begin
    if (evict_sel) begin
      memreq.op   = TYPE_WRITE;
      memreq.addr = {victim_tag, idx, {IDX_LSB{1'b0}}};
      memreq.data = read_line;
    end else begin
      memreq.op   = TYPE_READ;
      memreq.addr = {req_reg.addr[31:IDX_LSB], {IDX_LSB{1'b0}}};
      memreq.data = '0;
    end
  end

endmodule

// ==== blocking_cache.sv ====
// Two-way set-associative blocking write-back cache
// Controller FSM plus tag state and data path
`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  cache_req_t  cachereq,
  input  logic        cachereq_val,
  output logic        cachereq_rdy,

  output cache_resp_t cacheresp,
  output logic        cacheresp_val,
  input  logic        cacheresp_rdy,

  output mem_req_t    memreq,
  output logic        memreq_val,
  input  logic        memreq_rdy,

  input  mem_resp_t   memresp,
  input  logic        memresp_val,
  output logic        memresp_rdy
);

  // Controller to data modules
  logic req_en;
  logic refill_en;
  logic tag_ren;
  logic tag_wen;
  logic data_wen;
  logic refill_sel;
  logic read_en;
  logic evict_sel;
  logic way_record_en;
  logic valid_wen;
  logic dirty_wen;
  logic dirty_in;
  logic lru_wen;

  // Status and shared request fields
  req_type_t req_type;
  addr_t     req_addr;
  logic      hit;
  logic      victim_dirty;
  logic      way;
  tag_t      victim_tag;

  cache_ctrl_fsm ctrl_i (
    .clk, .reset,
    .cachereq_val, .cachereq_rdy, .cacheresp_val, .cacheresp_rdy,
    .memreq_val, .memreq_rdy, .memresp_val, .memresp_rdy,
    .req_type, .hit, .victim_dirty,
    .req_en, .refill_en, .tag_ren, .tag_wen, .data_wen, .refill_sel,
    .read_en, .evict_sel, .way_record_en, .valid_wen, .dirty_wen,
    .dirty_in, .lru_wen
  );

  cache_tag_state tag_i (
    .clk, .reset, .req_addr,
    .tag_ren, .tag_wen, .way_record_en, .valid_wen, .dirty_wen,
    .dirty_in, .lru_wen,
    .hit, .victim_dirty, .way, .victim_tag
  );

  cache_data_path dpath_i (
    .clk, .reset, .cachereq,
    .req_en, .refill_en, .data_wen, .refill_sel, .read_en, .evict_sel,
    .way, .victim_tag, .memresp,
    .req_type, .req_addr, .cacheresp, .memreq
  );

endmodule

// ==== tb_main_memory.sv ====
// Line-wide main memory model for the cache testbench
// Answers refill reads and eviction writes with random ready stalls
`timescale 1ns/1ps

module tb_main_memory
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  mem_req_t  memreq,
  input  logic      memreq_val,
  output logic      memreq_rdy,
  output mem_resp_t memresp,
  output logic      memresp_val,
  input  logic      memresp_rdy
);

  // Lines written back by the cache, keyed by line address
  line_t stored [addr_t];

  // Untouched words hold their own address xor a fixed pattern
  function automatic line_t image_line(input addr_t base);
    line_t l;
    if (stored.exists(base)) return stored[base];
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[w*WORD_BITS +: WORD_BITS] = (base + addr_t'(4 * w)) ^ 32'hA5A5_0000;
    end
    return l;
  endfunction

  initial begin
    mem_req_t req;
    logic     fire;
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
    forever begin
      @(posedge clk);
      #2;
      memreq_rdy = !reset && (($urandom % 4) != 0);
      @(negedge clk);
      if (memreq_val && memreq_rdy) begin
        req = memreq;
        @(posedge clk);
        #2;
        memreq_rdy = 1'b0;
        repeat (int'($urandom % 3)) begin
          @(posedge clk);
          #2;
        end
        if (req.op == TYPE_WRITE) stored[req.addr] = req.data;
        memresp.op   = req.op;
        memresp.data = (req.op == TYPE_WRITE) ? '0 : image_line(req.addr);
        memresp_val  = 1'b1;
        fire         = 1'b0;
        while (!fire) begin
          @(negedge clk);
          fire = memresp_rdy;
          @(posedge clk);
          #2;
        end
        memresp_val = 1'b0;
        memresp     = '0;
      end
    end
  end

endmodule

// ==== tb_blocking_cache.sv ====
// Testbench for the blocking cache
// Replays the request table and checks responses, hit latency and memory traffic
`timescale 1ns/1ps

module tb_blocking_cache
  import cache_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int MAX_REQS       = 64;
  localparam int CYCLES_PER_REQ = 60;
  localparam int HIT_LATENCY    = 3;

  logic        clk = 1'b0;
  logic        reset;
  cache_req_t  cachereq;
  logic        cachereq_val;
  logic        cachereq_rdy;
  cache_resp_t cacheresp;
  logic        cacheresp_val;
  logic        cacheresp_rdy;
  mem_req_t    memreq;
  logic        memreq_val;
  logic        memreq_rdy;
  mem_resp_t   memresp;
  logic        memresp_val;
  logic        memresp_rdy;

  // Request table from the stimulus file
  req_type_t st_op         [MAX_REQS];
  addr_t     st_addr       [MAX_REQS];
  word_t     st_wdata      [MAX_REQS];
  word_t     st_rdata      [MAX_REQS];
  logic      st_refill     [MAX_REQS];
  logic      st_evict      [MAX_REQS];
  addr_t     st_evict_addr [MAX_REQS];
  line_t     st_evict_line [MAX_REQS];
  int        num_reqs = 0;
  logic      stim_loaded = 1'b0;

  // Memory transfers of the request in flight
  mem_req_t  seen_q[$];
  mem_req_t  memreq_last;
  logic      memreq_held = 1'b0;

  blocking_cache dut_i (
    .clk, .reset,
    .cachereq, .cachereq_val, .cachereq_rdy,
    .cacheresp, .cacheresp_val, .cacheresp_rdy,
    .memreq, .memreq_val, .memreq_rdy,
    .memresp, .memresp_val, .memresp_rdy
  );

  tb_main_memory mem_i (
    .clk, .reset,
    .memreq, .memreq_val, .memreq_rdy,
    .memresp, .memresp_val, .memresp_rdy
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_op(input string name, input req_type_t got, input req_type_t exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  // --------------------------------------------------
  // Memory request monitor
  // --------------------------------------------------
  always @(negedge clk) begin
    if (!reset) begin
      if (memreq_held) begin
        if (!memreq_val) fail_run("memreq_val dropped before memreq_rdy was high");
        compare_op("memreq.op", memreq.op, memreq_last.op);
        compare_addr("memreq.addr", memreq.addr, memreq_last.addr);
        compare_line("memreq.data", memreq.data, memreq_last.data);
      end
      if (memreq_val && memreq_rdy) seen_q.push_back(memreq);
      memreq_held = memreq_val && !memreq_rdy;
      memreq_last = memreq;
    end
  end

  // Eviction first, then the refill of the request's line
  task automatic check_traffic(input int i);
    mem_req_t refill_req;
    if (seen_q.size() != int'(st_refill[i]) + int'(st_evict[i]))
      fail_run($sformatf("request %0d made %0d memory requests, %0d were expected",
                         i, seen_q.size(), int'(st_refill[i]) + int'(st_evict[i])));
    if (st_evict[i]) begin
      if (seen_q[0].op != TYPE_WRITE) fail_run("dirty miss did not start with an eviction");
      compare_addr("memreq.addr", seen_q[0].addr, st_evict_addr[i]);
      compare_line("memreq.data", seen_q[0].data, st_evict_line[i]);
    end
    if (st_refill[i]) begin
      refill_req = seen_q[seen_q.size() - 1];
      if (refill_req.op != TYPE_READ) fail_run("miss did not end with a refill read");
      compare_addr("memreq.addr", refill_req.addr, st_addr[i] & ~32'hF);
    end
  endtask

  initial begin
    int          fd;
    string       text;
    req_type_t   op;
    addr_t       addr;
    word_t       wdata;
    word_t       rdata;
    logic        refill;
    logic        evict;
    addr_t       evict_addr;
    line_t       evict_line;
    logic        accepted;
    logic        done;
    logic        resp_seen;
    int          latency;
    int          resp_latency;
    cache_resp_t resp_first;

    void'($urandom(32'h7509));
    reset         = 1'b1;
    cachereq      = '0;
    cachereq_val  = 1'b0;
    cacheresp_rdy = 1'b0;

    fd = $fopen("cache_stim.txt", "r");
    if (fd == 0) fail_run("cannot open cache_stim.txt");
    while (!$feof(fd) && num_reqs < MAX_REQS) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() > 1 && text[0] != "#") begin
        if ($sscanf(text, "%h %h %h %h %h %h %h %h", op, addr, wdata, rdata,
                    refill, evict, evict_addr, evict_line) == 8) begin
          st_op[num_reqs]         = op;
          st_addr[num_reqs]       = addr;
          st_wdata[num_reqs]      = wdata;
          st_rdata[num_reqs]      = rdata;
          st_refill[num_reqs]     = refill;
          st_evict[num_reqs]      = evict;
          st_evict_addr[num_reqs] = evict_addr;
          st_evict_line[num_reqs] = evict_line;
          num_reqs++;
        end
      end
    end
    $fclose(fd);
    if (num_reqs == 0) fail_run("no requests found in cache_stim.txt");
    stim_loaded = 1'b1;

    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clk);
    if (!cachereq_rdy) fail_run("cachereq_rdy is low after reset");
    if (memreq_val || cacheresp_val) fail_run("a val output is high after reset");
    @(posedge clk);
    #DRIVE_DELAY;

    for (int i = 0; i < num_reqs; i++) begin
      seen_q.delete();
      cachereq.op   = st_op[i];
      cachereq.addr = st_addr[i];
      cachereq.data = st_wdata[i];
      cachereq_val  = 1'b1;
      accepted      = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = cachereq_rdy;
        @(posedge clk);
        #DRIVE_DELAY;
      end
      cachereq_val = 1'b0;
      cachereq     = '0;

      // Response with random back-pressure, held steady until taken
      latency   = 0;
      done      = 1'b0;
      resp_seen = 1'b0;
      while (!done) begin
        cacheresp_rdy = ($urandom % 3) != 0;
        @(negedge clk);
        latency++;
        if (cacheresp_val) begin
          if (!resp_seen) begin
            resp_seen    = 1'b1;
            resp_latency = latency;
            resp_first   = cacheresp;
          end else begin
            compare_op("cacheresp.op", cacheresp.op, resp_first.op);
            compare_word("cacheresp.data", cacheresp.data, resp_first.data);
          end
          done = cacheresp_rdy;
        end else if (resp_seen) begin
          fail_run("cacheresp_val dropped before cacheresp_rdy was high");
        end
        @(posedge clk);
        #DRIVE_DELAY;
      end
      cacheresp_rdy = 1'b0;

      compare_op("cacheresp.op", resp_first.op, st_op[i]);
      if (st_op[i] == TYPE_READ) compare_word("cacheresp.data", resp_first.data, st_rdata[i]);
      if (!st_refill[i] && resp_latency != HIT_LATENCY)
        fail_run($sformatf("hit response of request %0d came after %0d cycles instead of %0d",
                           i, resp_latency, HIT_LATENCY));
      check_traffic(i);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog scaled to the number of requests
  initial begin
    wait (stim_loaded);
    #((num_reqs * CYCLES_PER_REQ + 10) * CLK_PERIOD);
    fail_run("timeout, the cache stopped answering requests");
  end

endmodule

// ==== cache_stim.txt ====
# One cache request per line, all fields hex, op 0 is read and 1 is write
# op addr wdata exp_rdata refill evict evict_addr evict_line
0 00000100 00000000 a5a50100 1 0 00000000 0
0 00000104 00000000 a5a50104 0 0 00000000 0
1 00000108 deadbeef 00000000 0 0 00000000 0
0 00000108 00000000 deadbeef 0 0 00000000 0
0 00000180 00000000 a5a50180 1 0 00000000 0
0 00000204 00000000 a5a50204 1 1 00000100 a5a5010cdeadbeefa5a50104a5a50100
0 00000184 00000000 a5a50184 0 0 00000000 0
0 00000108 00000000 deadbeef 1 0 00000000 0
1 00000284 12345678 00000000 1 0 00000000 0
0 00000284 00000000 12345678 0 0 00000000 0
0 00000200 00000000 a5a50200 1 0 00000000 0
0 00000300 00000000 a5a50300 1 1 00000280 a5a5028ca5a5028812345678a5a50280
0 00000284 00000000 12345678 1 0 00000000 0
1 80001234 cafef00d 00000000 1 0 00000000 0
0 80001234 00000000 cafef00d 0 0 00000000 0
0 80001238 00000000 25a51238 0 0 00000000 0
0 000012b0 00000000 a5a512b0 1 0 00000000 0
0 00001330 00000000 a5a51330 1 1 80001230 25a5123c25a51238cafef00d25a51230
0 80001234 00000000 cafef00d 1 0 00000000 0
0 00000070 00000000 a5a50070 1 0 00000000 0
1 0000007c 0badcafe 00000000 0 0 00000000 0
0 0000007c 00000000 0badcafe 0 0 00000000 0
0 00000074 00000000 a5a50074 0 0 00000000 0
1 000000f0 55aa55aa 00000000 1 0 00000000 0
1 00000170 11112222 00000000 1 1 00000070 0badcafea5a50078a5a50074a5a50070
0 00000170 00000000 11112222 0 0 00000000 0
0 0000007c 00000000 0badcafe 1 1 000000f0 a5a500fca5a500f8a5a500f455aa55aa

// ==== sources.f ====
cache_pkg.sv
cache_ctrl_fsm.sv
cache_tag_state.sv
cache_data_path.sv
blocking_cache.sv
tb_main_memory.sv
tb_blocking_cache.sv

// ==== Makefile ====
# Verilator build and run for the blocking cache testbench

TOP = tb_blocking_cache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
